// File: Bender.yml
package:
  name: color_mapper

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/duck_geom_pkg.sv
      - rtl/duck_color_pkg.sv
      - rtl/shot_tracker.sv
      - rtl/sprite_coverage.sv
      - rtl/pixel_compositor.sv
      - rtl/color_mapper.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - dv/color_mapper_assert.sv
      - dv/color_mapper_tb.sv

// File: color_mapper.f
+incdir+rtl
rtl/duck_geom_pkg.sv
rtl/duck_color_pkg.sv
rtl/shot_tracker.sv
rtl/sprite_coverage.sv
rtl/pixel_compositor.sv
rtl/color_mapper.sv
dv/color_mapper_assert.sv
dv/color_mapper_tb.sv

// File: dv/color_mapper_assert.sv
// concurrent checks on the shot tracker and their bind
`timescale 1ns/1ns
`include "duck_defs.svh"

module color_mapper_assert #(
	parameter int FLASH_CYCLES = 8
) (
	input logic                         vga_clk,
	input logic                         Reset,
	input duck_geom_pkg::button_t       mouse_buttons,
	input logic                         new_round,
	input logic                         shot_on,
	input duck_geom_pkg::bullet_count_t bullet_count,
	input logic                         duck_kill
);

	// a full count stays at three until the next round
	a_bullet_sat : assert property (@(posedge vga_clk) disable iff (Reset)
		bullet_count == 2'd3 && !new_round |=> bullet_count == 2'd3)
		else $error("bullet count wrapped past three");

	// flash ends within its length
	a_flash_len : assert property (@(posedge vga_clk) disable iff (Reset)
		$rose(shot_on) |-> ##[1:FLASH_CYCLES] !shot_on)
		else $error("shot flash held too long");

	// a kill needs a flash frame started by the trigger
	a_kill_flash : assert property (@(posedge vga_clk) disable iff (Reset)
		duck_kill |-> shot_on && $past(mouse_buttons) == `BTN_RIGHT)
		else $error("duck kill outside a trigger flash");

endmodule

bind shot_tracker color_mapper_assert #(
	.FLASH_CYCLES (FLASH_CYCLES)
) u_color_mapper_assert (
	.vga_clk       (vga_clk),
	.Reset         (Reset),
	.mouse_buttons (mouse_buttons),
	.new_round     (new_round),
	.shot_on       (shot_on),
	.bullet_count  (bullet_count),
	.duck_kill     (duck_kill)
);

// File: dv/color_mapper_tb.sv
// clock, reset, stimulus table, reference model, compare tasks and watchdog
`timescale 1ns/1ns
`include "duck_defs.svh"

module color_mapper_tb;

	localparam int FLASH_LEN    = 8;
	localparam int RESET_CYCLES = 10;
	localparam int WATCH_MARGIN = 60;

	logic vga_clk;
	logic Reset;
	logic blank;
	duck_geom_pkg::coord_t draw_x;
	duck_geom_pkg::coord_t draw_y;
	duck_geom_pkg::coord_t cursor_x;
	duck_geom_pkg::coord_t cursor_y;
	duck_geom_pkg::coord_t cursor_size;
	duck_geom_pkg::duck_coord_t duck_x;
	duck_geom_pkg::duck_coord_t duck_y;
	duck_color_pkg::duck_color_t duck_color;
	duck_geom_pkg::kill_mask_t kill_mask;
	duck_geom_pkg::button_t mouse_buttons;
	logic game_started;
	logic new_round;
	duck_color_pkg::channel_t red;
	duck_color_pkg::channel_t green;
	duck_color_pkg::channel_t blue;
	logic duck_kill;
	logic start_game;

	// stimulus table columns with one entry per named row
	string t_name[$];
	logic t_blank[$];
	logic t_rnd[$];
	logic t_gs[$];
	logic t_nr[$];
	int t_dx[$];
	int t_dy[$];
	int t_cx[$];
	int t_cy[$];
	int t_csz[$];
	int t_kx[$];
	int t_ky[$];
	int t_col[$];
	int t_mask[$];
	int t_btn[$];
	int t_hold[$];

	// reference model state
	int m_state;
	int m_left;
	int m_bullets;
	logic m_trig_q;

	int unsigned lcg_state = 32'd38706;
	int row_errors;
	int total_errors;
	int rows_passed;
	int rows_failed;
	int watch_cycles;
	int exp_rgb;
	string rgb_name;
	string cur_name;
	logic table_ready = 1'b0;

	color_mapper #(
		.FLASH_CYCLES (FLASH_LEN)
	) u_color_mapper (
		.vga_clk (vga_clk), .Reset (Reset), .blank (blank),
		.draw_x (draw_x), .draw_y (draw_y),
		.cursor_x (cursor_x), .cursor_y (cursor_y), .cursor_size (cursor_size),
		.duck_x (duck_x), .duck_y (duck_y), .duck_color (duck_color),
		.kill_mask (kill_mask), .mouse_buttons (mouse_buttons),
		.game_started (game_started), .new_round (new_round),
		.red (red), .green (green), .blue (blue),
		.duck_kill (duck_kill), .start_game (start_game)
	);

	initial
	begin
		vga_clk = 1'b0;
		forever #10 vga_clk = ~vga_clk;
	end

	// --------------------------------------------------
	// random draw points
	// --------------------------------------------------
	function automatic int unsigned lcg_next();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state >> 16;
	endfunction

	// --------------------------------------------------
	// reference model
	// --------------------------------------------------
	function automatic int abs_int(int v);
		return (v < 0) ? -v : v;
	endfunction

	// colour of the pixel on the inputs before the edge
	function automatic int pixel_model();
		int cx;
		int cy;
		int ex;
		int ey;
		int sx;
		cx = abs_int(int'(draw_x) - int'(cursor_x));
		cy = abs_int(int'(draw_y) - int'(cursor_y));
		ex = int'(draw_x) - int'(duck_x);
		ey = int'(draw_y) - int'(duck_y);
		if (!blank)
			return `BLACK_RGB;
		// flash frame hides everything else
		if (m_state == 1)
			return (cx <= `FLASH_HALF && cy <= `FLASH_HALF) ? `WHITE_RGB : `BLACK_RGB;
		if (cx + cy <= int'(cursor_size))
			return `WHITE_RGB;
		if (int'(duck_y) < `GRASS_Y && ex >= 0 && ex < `DUCK_BOX && ey >= 0 && ey < `DUCK_BOX)
		begin
			case (int'(duck_color))
				0: return `DUCK_BLACK_RGB;
				1: return `DUCK_RED_RGB;
				2: return `DUCK_PINK_RGB;
				default: return `BLACK_RGB;
			endcase
		end
		// bullet squares spent from the right
		for (int i = 0; i < 3; i++)
		begin
			sx = `BULLET_X0 + i * `BULLET_PITCH;
			if (draw_y >= `BULLET_Y0 && draw_y < `BULLET_Y0 + `BULLET_H
				&& draw_x >= sx && draw_x < sx + `BULLET_W
				&& game_started && i + m_bullets <= 2)
				return `HUD_GREY;
		end
		if (game_started)
		begin
			for (int i = 0; i < 10; i++)
			begin
				sx = int'(draw_x) - (`TALLY_X0 + i * `TALLY_PITCH);
				ey = int'(draw_y) - `TALLY_Y;
				if (sx * sx + ey * ey <= `TALLY_R2)
					return kill_mask[i] ? `TALLY_RED : `WHITE_RGB;
			end
		end
		return game_started ? `SKY_RGB : `MENU_RGB;
	endfunction

	// advance flash fsm and bullet count by one edge
	task automatic step_model();
		logic held;
		logic rise;
		held = (mouse_buttons == `BTN_RIGHT);
		rise = held && !m_trig_q;
		if (!held)
			m_state = 0;
		else if (m_state == 0)
		begin
			m_state = 1;
			m_left  = FLASH_LEN - 1;
		end
		else if (m_state == 1)
		begin
			if (m_left == 0)
				m_state = 2;
			else
				m_left--;
		end
		if (rise && m_bullets < 3)
			m_bullets++;
		else if (new_round)
			m_bullets = 0;
		m_trig_q = held;
	endtask

	function automatic logic kill_model();
		return m_state == 1
			&& int'(cursor_x) > int'(duck_x) + 2 && int'(cursor_x) < int'(duck_x) + `DUCK_BOX - 1
			&& int'(cursor_y) > int'(duck_y) + 2 && int'(cursor_y) < int'(duck_y) + `DUCK_BOX - 1;
	endfunction

	function automatic logic start_model();
		return !game_started && mouse_buttons == `BTN_LEFT
			&& cursor_x >= `START_X0 && cursor_x < `START_X1
			&& cursor_y >= `START_Y0 && cursor_y < `START_Y1;
	endfunction

	// --------------------------------------------------
	// compare tasks
	// --------------------------------------------------
	task automatic check_rgb(string name, duck_color_pkg::channel_t er,
		duck_color_pkg::channel_t eg, duck_color_pkg::channel_t eb,
		duck_color_pkg::channel_t ar, duck_color_pkg::channel_t ag,
		duck_color_pkg::channel_t ab);
		if ({ar, ag, ab} !== {er, eg, eb})
		begin
			$display("FAIL %s rgb expected %h%h%h actual %h%h%h", name, er, eg, eb, ar, ag, ab);
			row_errors++;
		end
	endtask

	task automatic check_flag(string name, string what, logic exp, logic act);
		if (act !== exp)
		begin
			$display("FAIL %s %s expected %b actual %b", name, what, exp, act);
			row_errors++;
		end
	endtask

	// --------------------------------------------------
	// table rows
	// --------------------------------------------------
	task automatic add_row(string name, logic blk, logic rnd, int dx, int dy, int cx, int cy,
		int csz, int kx, int ky, int col, int mask, int btn, logic gs, logic nr, int hold);
		t_name.push_back(name);
		t_blank.push_back(blk);
		t_rnd.push_back(rnd);
		t_dx.push_back(dx);
		t_dy.push_back(dy);
		t_cx.push_back(cx);
		t_cy.push_back(cy);
		t_csz.push_back(csz);
		t_kx.push_back(kx);
		t_ky.push_back(ky);
		t_col.push_back(col);
		t_mask.push_back(mask);
		t_btn.push_back(btn);
		t_gs.push_back(gs);
		t_nr.push_back(nr);
		t_hold.push_back(hold);
	endtask

	// edge then model then drive, with the check mid-cycle
	task automatic run_cycle(int r);
		@(posedge vga_clk);
		exp_rgb = pixel_model();
		step_model();
		rgb_name = cur_name;
		cur_name = t_name[r];
		blank         <= t_blank[r];
		draw_x        <= t_rnd[r] ? 10'(lcg_next() % `SCREEN_W) : 10'(t_dx[r]);
		draw_y        <= t_rnd[r] ? 10'(lcg_next() % `SCREEN_H) : 10'(t_dy[r]);
		cursor_x      <= 10'(t_cx[r]);
		cursor_y      <= 10'(t_cy[r]);
		cursor_size   <= 10'(t_csz[r]);
		duck_x        <= 11'(t_kx[r]);
		duck_y        <= 11'(t_ky[r]);
		duck_color    <= duck_color_pkg::duck_color_t'(t_col[r]);
		kill_mask     <= 10'(t_mask[r]);
		mouse_buttons <= 8'(t_btn[r]);
		game_started  <= t_gs[r];
		new_round     <= t_nr[r];
		@(negedge vga_clk);
		check_rgb(rgb_name, exp_rgb[11:8], exp_rgb[7:4], exp_rgb[3:0], red, green, blue);
		check_flag(cur_name, "shot_on", m_state == 1, u_color_mapper.shot_on);
		check_flag(cur_name, "duck_kill", kill_model(), duck_kill);
		check_flag(cur_name, "start_game", start_model(), start_game);
	endtask

	task automatic build_table();
		// name blank rnd draw cursor size duck colour mask button started round hold
		add_row("blank_black", 0, 1, 0, 0, 320, 240, 6, 100, 100, 1, 10'h3FF, 2, 1, 0, 20);
		add_row("release_0", 1, 0, 5, 5, 320, 240, 6, 100, 300, 0, 0, 0, 0, 0, 2);
		add_row("menu_sweep", 1, 1, 0, 0, 320, 240, 6, 100, 300, 0, 0, 0, 0, 0, 40);
		add_row("menu_cursor", 1, 0, 322, 241, 320, 240, 6, 100, 300, 0, 0, 0, 0, 0, 3);
		add_row("start_press", 1, 0, 250, 220, 250, 220, 6, 100, 300, 0, 0, 1, 0, 0, 3);
		add_row("start_edge_x", 1, 0, 250, 220, 301, 220, 6, 100, 300, 0, 0, 1, 0, 0, 3);
		add_row("start_edge_y", 1, 0, 250, 220, 250, 199, 6, 100, 300, 0, 0, 1, 0, 0, 3);
		add_row("start_in_game", 1, 0, 250, 220, 250, 220, 6, 100, 300, 0, 0, 1, 1, 0, 3);
		add_row("new_round", 1, 0, 104, 420, 500, 100, 6, 100, 300, 0, 0, 0, 1, 1, 2);
		add_row("slot2_n0", 1, 0, 104, 420, 500, 100, 6, 100, 300, 0, 0, 0, 1, 0, 2);
		add_row("flash_in", 1, 0, 310, 110, 300, 100, 6, 100, 300, 0, 0, 2, 1, 0, 12);
		add_row("release_1", 1, 0, 310, 110, 300, 100, 6, 100, 300, 0, 0, 0, 1, 0, 2);
		add_row("slot2_n1", 1, 0, 104, 420, 500, 100, 6, 100, 300, 0, 0, 0, 1, 0, 2);
		add_row("slot1_n1", 1, 0, 87, 420, 500, 100, 6, 100, 300, 0, 0, 0, 1, 0, 2);
		add_row("flash_out", 1, 0, 340, 100, 300, 100, 6, 100, 300, 0, 0, 2, 1, 0, 12);
		add_row("release_2", 1, 0, 340, 100, 300, 100, 6, 100, 300, 0, 0, 0, 1, 0, 2);
		add_row("slot1_n2", 1, 0, 87, 420, 500, 100, 6, 100, 300, 0, 0, 0, 1, 0, 2);
		add_row("slot0_n2", 1, 0, 70, 420, 500, 100, 6, 100, 300, 0, 0, 0, 1, 0, 2);
		add_row("flash_3", 1, 0, 70, 420, 500, 100, 6, 100, 300, 0, 0, 2, 1, 0, 10);
		add_row("release_3", 1, 0, 70, 420, 500, 100, 6, 100, 300, 0, 0, 0, 1, 0, 2);
		add_row("slot0_n3", 1, 0, 70, 420, 500, 100, 6, 100, 300, 0, 0, 0, 1, 0, 2);
		add_row("flash_sat", 1, 0, 70, 420, 500, 100, 6, 100, 300, 0, 0, 2, 1, 0, 10);
		add_row("release_4", 1, 0, 70, 420, 500, 100, 6, 100, 300, 0, 0, 0, 1, 0, 2);
		add_row("round_clear", 1, 0, 70, 420, 500, 100, 6, 100, 300, 0, 0, 0, 1, 1, 2);
		add_row("slot0_restored", 1, 0, 70, 420, 500, 100, 6, 100, 300, 0, 0, 0, 1, 0, 2);
		add_row("slot2_restored", 1, 0, 104, 420, 500, 100, 6, 100, 300, 0, 0, 0, 1, 0, 2);
		add_row("kill_inside", 1, 0, 330, 130, 330, 130, 6, 300, 100, 1, 0, 2, 1, 0, 10);
		add_row("release_5", 1, 0, 330, 130, 330, 130, 6, 300, 100, 1, 0, 0, 1, 0, 2);
		add_row("kill_left_out", 1, 0, 302, 130, 302, 130, 6, 300, 100, 1, 0, 2, 1, 0, 10);
		add_row("release_6", 1, 0, 302, 130, 302, 130, 6, 300, 100, 1, 0, 0, 1, 0, 2);
		add_row("kill_right_in", 1, 0, 362, 130, 362, 130, 6, 300, 100, 1, 0, 2, 1, 0, 10);
		add_row("release_7", 1, 0, 362, 130, 362, 130, 6, 300, 100, 1, 0, 0, 1, 0, 2);
		add_row("kill_right_out", 1, 0, 363, 130, 363, 130, 6, 300, 100, 1, 0, 2, 1, 0, 10);
		add_row("release_8", 1, 0, 363, 130, 363, 130, 6, 300, 100, 1, 0, 0, 1, 0, 2);
		add_row("tally_killed", 1, 0, 228, 424, 500, 100, 6, 100, 300, 0, 10'h001, 0, 1, 0, 2);
		add_row("tally_missed", 1, 0, 250, 424, 500, 100, 6, 100, 300, 0, 10'h001, 0, 1, 0, 2);
		add_row("tally_menu", 1, 0, 228, 424, 500, 100, 6, 100, 300, 0, 10'h001, 0, 0, 0, 2);
		add_row("game_sweep", 1, 1, 0, 0, 320, 240, 6, 400, 150, 2, 10'h2AA, 0, 1, 0, 60);
		add_row("duck_black", 1, 0, 120, 120, 500, 300, 6, 100, 100, 0, 0, 0, 1, 0, 2);
		add_row("duck_red", 1, 0, 120, 120, 500, 300, 6, 100, 100, 1, 0, 0, 1, 0, 2);
		add_row("duck_pink", 1, 0, 120, 120, 500, 300, 6, 100, 100, 2, 0, 0, 1, 0, 2);
		add_row("duck_code3", 1, 0, 120, 120, 500, 300, 6, 100, 100, 3, 0, 0, 1, 0, 2);
		add_row("duck_grass", 1, 0, 120, 250, 500, 100, 6, 100, 237, 1, 0, 0, 1, 0, 2);
		add_row("duck_above", 1, 0, 120, 250, 500, 100, 6, 100, 236, 1, 0, 0, 1, 0, 2);
	endtask

	// --------------------------------------------------
	// main sequence
	// --------------------------------------------------
	initial
	begin
		Reset <= 1'b1;
		blank <= 1'b0;
		draw_x <= '0;
		draw_y <= '0;
		cursor_x <= '0;
		cursor_y <= '0;
		cursor_size <= '0;
		duck_x <= '0;
		duck_y <= '0;
		duck_color <= duck_color_pkg::DUCK_BLACK;
		kill_mask <= '0;
		mouse_buttons <= '0;
		game_started <= 1'b0;
		new_round <= 1'b0;
		m_state = 0;
		m_left = 0;
		m_bullets = 0;
		m_trig_q = 1'b0;
		total_errors = 0;
		rows_passed = 0;
		rows_failed = 0;
		cur_name = "reset";
		build_table();
		watch_cycles = RESET_CYCLES + WATCH_MARGIN;
		foreach (t_hold[i])
			watch_cycles += t_hold[i];
		table_ready = 1'b1;
		repeat (RESET_CYCLES) @(posedge vga_clk);
		Reset <= 1'b0;
		foreach (t_name[r])
		begin
			row_errors = 0;
			for (int c = 0; c < t_hold[r]; c++)
				run_cycle(r);
			// last pixel of the final row still in the register
			if (r == t_name.size() - 1)
				run_cycle(r);
			if (row_errors == 0)
			begin
				rows_passed++;
				$display("pass %s", t_name[r]);
			end
			else
			begin
				rows_failed++;
				$display("fail %s with %0d mismatches", t_name[r], row_errors);
			end
			total_errors += row_errors;
		end
		$display("rows passed %0d, rows failed %0d, mismatches %0d",
			rows_passed, rows_failed, total_errors);
		if (total_errors == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

	// run length from the table plus reset and margin
	initial
	begin
		wait (table_ready);
		repeat (watch_cycles) @(posedge vga_clk);
		$display("watchdog expired before the stimulus table finished");
		$display("Test FAILED");
		$finish;
	end

endmodule

// File: rtl/color_mapper.sv
// top level with shot tracker and sprite coverage feeding the compositor
`timescale 1ns/1ns
`include "duck_defs.svh"

module color_mapper #(
	parameter int FLASH_CYCLES = `SHOT_FLASH_CYCLES
) (
	input  logic                        vga_clk,
	input  logic                        Reset,
	input  logic                        blank,
	input  duck_geom_pkg::coord_t       draw_x,
	input  duck_geom_pkg::coord_t       draw_y,
	input  duck_geom_pkg::coord_t       cursor_x,
	input  duck_geom_pkg::coord_t       cursor_y,
	input  duck_geom_pkg::coord_t       cursor_size,
	input  duck_geom_pkg::duck_coord_t  duck_x,
	input  duck_geom_pkg::duck_coord_t  duck_y,
	input  duck_color_pkg::duck_color_t duck_color,
	input  duck_geom_pkg::kill_mask_t   kill_mask,
	input  duck_geom_pkg::button_t      mouse_buttons,
	input  logic                        game_started,
	input  logic                        new_round,
	output duck_color_pkg::channel_t    red,
	output duck_color_pkg::channel_t    green,
	output duck_color_pkg::channel_t    blue,
	output logic                        duck_kill,
	output logic                        start_game
);

	// tracker to compositor
	logic shot_on;
	duck_geom_pkg::bullet_count_t bullet_count;
	// coverage to compositor
	logic cursor_hit;
	logic flash_hit;
	logic duck_hit;
	logic bullet_slot_hit;
	duck_geom_pkg::bullet_count_t bullet_slot;
	logic tally_hit;
	logic tally_killed;

	shot_tracker #(
		.FLASH_CYCLES (FLASH_CYCLES)
	) u_shot_tracker (
		.vga_clk       (vga_clk),
		.Reset         (Reset),
		.cursor_x      (cursor_x),
		.cursor_y      (cursor_y),
		.duck_x        (duck_x),
		.duck_y        (duck_y),
		.mouse_buttons (mouse_buttons),
		.game_started  (game_started),
		.new_round     (new_round),
		.shot_on       (shot_on),
		.bullet_count  (bullet_count),
		.duck_kill     (duck_kill),
		.start_game    (start_game)
	);

	sprite_coverage u_sprite_coverage (
		.draw_x          (draw_x),
		.draw_y          (draw_y),
		.cursor_x        (cursor_x),
		.cursor_y        (cursor_y),
		.cursor_size     (cursor_size),
		.duck_x          (duck_x),
		.duck_y          (duck_y),
		.kill_mask       (kill_mask),
		.cursor_hit      (cursor_hit),
		.flash_hit       (flash_hit),
		.duck_hit        (duck_hit),
		.bullet_slot_hit (bullet_slot_hit),
		.bullet_slot     (bullet_slot),
		.tally_hit       (tally_hit),
		.tally_killed    (tally_killed)
	);

	pixel_compositor u_pixel_compositor (
		.vga_clk         (vga_clk),
		.Reset           (Reset),
		.blank           (blank),
		.game_started    (game_started),
		.duck_color      (duck_color),
		.shot_on         (shot_on),
		.bullet_count    (bullet_count),
		.cursor_hit      (cursor_hit),
		.flash_hit       (flash_hit),
		.duck_hit        (duck_hit),
		.bullet_slot_hit (bullet_slot_hit),
		.bullet_slot     (bullet_slot),
		.tally_hit       (tally_hit),
		.tally_killed    (tally_killed),
		.red             (red),
		.green           (green),
		.blue            (blue)
	);

endmodule

// File: rtl/duck_color_pkg.sv
// colour channel, duck colour and shot state types
package duck_color_pkg;

	// one vga colour channel
	typedef logic [3:0] channel_t;

	// duck breed sets the box colour
	// code 3 is unused and shows black
	typedef enum logic [1:0] {
		DUCK_BLACK = 2'd0,
		DUCK_RED   = 2'd1,
		DUCK_PINK  = 2'd2
	} duck_color_t;

	// trigger flash fsm
	typedef enum logic [1:0] {
		SHOT_IDLE  = 2'd0,
		SHOT_FLASH = 2'd1,
		SHOT_SPENT = 2'd2
	} shot_state_t;

endpackage

// File: rtl/duck_defs.svh
// screen geometry, hud placement, button codes, colours and flash length
`ifndef DUCK_DEFS_SVH
`define DUCK_DEFS_SVH

// visible screen
`define SCREEN_W           640
`define SCREEN_H           480

// duck box hidden once its top reaches the grass
`define DUCK_BOX           64
`define GRASS_Y            237

// start button with exclusive upper bounds
`define START_X0           200
`define START_X1           301
`define START_Y0           200
`define START_Y1           251

// shot flash square and its length in pixel clocks
`define FLASH_HALF         25
`define SHOT_FLASH_CYCLES  1000000

// bullet squares with slot 0 leftmost
`define BULLET_COUNT       3
`define BULLET_X0          68
`define BULLET_PITCH       17
`define BULLET_W           9
`define BULLET_Y0          418
`define BULLET_H           13

// duck tally circles
`define TALLY_COUNT        10
`define TALLY_X0           228
`define TALLY_PITCH        22
`define TALLY_Y            424
`define TALLY_R2           36
// band holding all ten circles
`define TALLY_BAND_X0      200
`define TALLY_BAND_X1      434
`define TALLY_BAND_Y0      417
`define TALLY_BAND_Y1      432

// mouse button codes
`define BTN_LEFT           8'd1
`define BTN_RIGHT          8'd2

// 12-bit rgb with red in the top nibble
`define BLACK_RGB          12'h000
`define WHITE_RGB          12'hFFF
`define MENU_RGB           12'h238
`define SKY_RGB            12'h6AF
`define HUD_GREY           12'hAAA
`define TALLY_RED          12'hD00
`define DUCK_BLACK_RGB     12'h321
`define DUCK_RED_RGB       12'hC30
`define DUCK_PINK_RGB      12'hF9C

`endif

// File: rtl/duck_geom_pkg.sv
// coordinate, button, bullet count, kill mask and tally index types
package duck_geom_pkg;

	// on-screen pixel coordinate
	typedef logic [9:0] coord_t;

	// duck position that may sit off screen
	typedef logic signed [10:0] duck_coord_t;

	// mouse button code as sent by the mouse block
	typedef logic [7:0] button_t;

	// shots spent this round from 0 to 3
	typedef logic [1:0] bullet_count_t;

	// one bit per duck of the round set when hit
	typedef logic [9:0] kill_mask_t;

	// which tally circle
	typedef logic [3:0] tally_idx_t;

endpackage

// File: rtl/pixel_compositor.sv
// layer priority and registered rgb output
`timescale 1ns/1ns
`include "duck_defs.svh"

module pixel_compositor (
	input  logic                         vga_clk,
	input  logic                         Reset,
	input  logic                         blank,
	input  logic                         game_started,
	input  duck_color_pkg::duck_color_t  duck_color,
	input  logic                         shot_on,
	input  duck_geom_pkg::bullet_count_t bullet_count,
	input  logic                         cursor_hit,
	input  logic                         flash_hit,
	input  logic                         duck_hit,
	input  logic                         bullet_slot_hit,
	input  duck_geom_pkg::bullet_count_t bullet_slot,
	input  logic                         tally_hit,
	input  logic                         tally_killed,
	output duck_color_pkg::channel_t     red,
	output duck_color_pkg::channel_t     green,
	output duck_color_pkg::channel_t     blue
);

	logic [11:0] rgb_next;
	logic bullet_shown;

	// slot i stays until 3-i shots are spent
	assign bullet_shown = ({1'b0, bullet_slot} + {1'b0, bullet_count}) <= 3'd2;

	// --------------------------------------------------
	// layer priority where the first match wins
	// --------------------------------------------------
	always_comb
	begin
		if (!blank)
		begin
			rgb_next = `BLACK_RGB;
		end
		else if (shot_on)
		begin
			// light-gun frame shows only the square around the aim
			rgb_next = flash_hit ? `WHITE_RGB : `BLACK_RGB;
		end
		else if (cursor_hit)
		begin
			rgb_next = `WHITE_RGB;
		end
		else if (duck_hit)
		begin
			case (duck_color)
				duck_color_pkg::DUCK_BLACK: rgb_next = `DUCK_BLACK_RGB;
				duck_color_pkg::DUCK_RED:   rgb_next = `DUCK_RED_RGB;
				duck_color_pkg::DUCK_PINK:  rgb_next = `DUCK_PINK_RGB;
				default:                    rgb_next = `BLACK_RGB;
			endcase
		end
		else if (bullet_slot_hit && game_started && bullet_shown)
		begin
			rgb_next = `HUD_GREY;
		end
		else if (tally_hit && game_started)
		begin
			rgb_next = tally_killed ? `TALLY_RED : `WHITE_RGB;
		end
		else
		begin
			// flat sky in game and menu colour before
			rgb_next = game_started ? `SKY_RGB : `MENU_RGB;
		end
	end

	// one pixel of latency
	always_ff @(posedge vga_clk or posedge Reset)
	begin
		if (Reset)
		begin
			red   <= '0;
			green <= '0;
			blue  <= '0;
		end
		else
		begin
			red   <= rgb_next[11:8];
			green <= rgb_next[7:4];
			blue  <= rgb_next[3:0];
		end
	end

endmodule

// File: rtl/shot_tracker.sv
// trigger flash fsm, bullet counter, duck hit and start button tests
`timescale 1ns/1ns
`include "duck_defs.svh"

module shot_tracker #(
	parameter int FLASH_CYCLES = `SHOT_FLASH_CYCLES
) (
	input  logic                         vga_clk,
	input  logic                         Reset,
	input  duck_geom_pkg::coord_t        cursor_x,
	input  duck_geom_pkg::coord_t        cursor_y,
	input  duck_geom_pkg::duck_coord_t   duck_x,
	input  duck_geom_pkg::duck_coord_t   duck_y,
	input  duck_geom_pkg::button_t       mouse_buttons,
	input  logic                         game_started,
	input  logic                         new_round,
	output logic                         shot_on,
	output duck_geom_pkg::bullet_count_t bullet_count,
	output logic                         duck_kill,
	output logic                         start_game
);

	// flash counter is at least one bit wide
	localparam int CNT_W = (FLASH_CYCLES > 1) ? $clog2(FLASH_CYCLES) : 1;
	localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(FLASH_CYCLES - 1);

	duck_color_pkg::shot_state_t state;
	duck_color_pkg::shot_state_t state_next;
	logic [CNT_W-1:0] flash_cnt;
	logic trigger_held;
	logic trigger_q;
	logic trigger_rise;
	logic signed [11:0] cur_x_s;
	logic signed [11:0] cur_y_s;
	logic signed [11:0] duck_x_s;
	logic signed [11:0] duck_y_s;

	// --------------------------------------------------
	// trigger
	// --------------------------------------------------
	assign trigger_held = (mouse_buttons == `BTN_RIGHT);
	// first cycle of a press
	assign trigger_rise = trigger_held & ~trigger_q;

	// --------------------------------------------------
	// flash fsm
	// --------------------------------------------------
	always_comb
	begin
		state_next = state;
		// release wins from any state
		if (!trigger_held)
		begin
			state_next = duck_color_pkg::SHOT_IDLE;
		end
		else if (state == duck_color_pkg::SHOT_IDLE)
		begin
			state_next = duck_color_pkg::SHOT_FLASH;
		end
		else if (state == duck_color_pkg::SHOT_FLASH && flash_cnt == CNT_LAST)
		begin
			// flash over so wait here for release
			state_next = duck_color_pkg::SHOT_SPENT;
		end
	end

	always_ff @(posedge vga_clk or posedge Reset)
	begin
		if (Reset)
		begin
			state     <= duck_color_pkg::SHOT_IDLE;
			flash_cnt <= '0;
			trigger_q <= 1'b0;
		end
		else
		begin
			state     <= state_next;
			trigger_q <= trigger_held;
			// counts flash cycles already shown
			if (state == duck_color_pkg::SHOT_FLASH && state_next == duck_color_pkg::SHOT_FLASH)
			begin
				flash_cnt <= flash_cnt + 1'b1;
			end
			else
			begin
				flash_cnt <= '0;
			end
		end
	end

	assign shot_on = (state == duck_color_pkg::SHOT_FLASH);

	// --------------------------------------------------
	// bullets spent
	// --------------------------------------------------
	always_ff @(posedge vga_clk or posedge Reset)
	begin
		if (Reset)
		begin
			bullet_count <= '0;
		end
		else if (trigger_rise && bullet_count != 2'd3)
		begin
			bullet_count <= bullet_count + 2'd1;
		end
		else if (new_round)
		begin
			// fresh round gives all three back
			bullet_count <= '0;
		end
	end

	// --------------------------------------------------
	// hit tests
	// --------------------------------------------------
	assign cur_x_s  = $signed({2'b00, cursor_x});
	assign cur_y_s  = $signed({2'b00, cursor_y});
	assign duck_x_s = $signed({duck_x[10], duck_x});
	assign duck_y_s = $signed({duck_y[10], duck_y});

	// strictly inside with 2 px in on left and top and 1 px on right and bottom
	assign duck_kill = shot_on
		&& cur_x_s > duck_x_s + 12'sd2 && cur_x_s < duck_x_s + `DUCK_BOX - 1
		&& cur_y_s > duck_y_s + 12'sd2 && cur_y_s < duck_y_s + `DUCK_BOX - 1;

	// left click on start button in the menu only
	assign start_game = !game_started && mouse_buttons == `BTN_LEFT
		&& cursor_x >= `START_X0 && cursor_x < `START_X1
		&& cursor_y >= `START_Y0 && cursor_y < `START_Y1;

endmodule

// File: rtl/sprite_coverage.sv
// per-pixel tests for cursor, flash square, duck box, bullets and tally
`timescale 1ns/1ns
`include "duck_defs.svh"

module sprite_coverage (
	input  duck_geom_pkg::coord_t        draw_x,
	input  duck_geom_pkg::coord_t        draw_y,
	input  duck_geom_pkg::coord_t        cursor_x,
	input  duck_geom_pkg::coord_t        cursor_y,
	input  duck_geom_pkg::coord_t        cursor_size,
	input  duck_geom_pkg::duck_coord_t   duck_x,
	input  duck_geom_pkg::duck_coord_t   duck_y,
	input  duck_geom_pkg::kill_mask_t    kill_mask,
	output logic                         cursor_hit,
	output logic                         flash_hit,
	output logic                         duck_hit,
	output logic                         bullet_slot_hit,
	output duck_geom_pkg::bullet_count_t bullet_slot,
	output logic                         tally_hit,
	output logic                         tally_killed
);

	logic signed [11:0] draw_x_s;
	logic signed [11:0] draw_y_s;
	logic signed [11:0] cur_dx;
	logic signed [11:0] cur_dy;
	logic [10:0] cur_abs_x;
	logic [10:0] cur_abs_y;
	logic signed [11:0] duck_dx;
	logic signed [11:0] duck_dy;
	logic in_bullet_row;
	logic in_tally_band;
	int tally_dx;
	int tally_dy;
	int tally_dy2;
	duck_geom_pkg::tally_idx_t tally_idx;

	assign draw_x_s = $signed({2'b00, draw_x});
	assign draw_y_s = $signed({2'b00, draw_y});

	// --------------------------------------------------
	// cursor diamond and flash square
	// --------------------------------------------------
	assign cur_dx = draw_x_s - $signed({2'b00, cursor_x});
	assign cur_dy = draw_y_s - $signed({2'b00, cursor_y});
	assign cur_abs_x = 11'(cur_dx < 0 ? -cur_dx : cur_dx);
	assign cur_abs_y = 11'(cur_dy < 0 ? -cur_dy : cur_dy);

	// |dx| + |dy| <= size
	assign cursor_hit = ({1'b0, cur_abs_x} + {1'b0, cur_abs_y}) <= {2'b00, cursor_size};

	// square of side 2*half+1 centred on the cursor
	assign flash_hit = cur_dx >= -`FLASH_HALF && cur_dx <= `FLASH_HALF
		&& cur_dy >= -`FLASH_HALF && cur_dy <= `FLASH_HALF;

	// --------------------------------------------------
	// duck box
	// --------------------------------------------------
	assign duck_dx = draw_x_s - $signed({duck_x[10], duck_x});
	assign duck_dy = draw_y_s - $signed({duck_y[10], duck_y});

	// gone once it drops behind the grass
	assign duck_hit = duck_y < `GRASS_Y
		&& duck_dx >= 0 && duck_dx < `DUCK_BOX
		&& duck_dy >= 0 && duck_dy < `DUCK_BOX;

	// --------------------------------------------------
	// bullet squares
	// --------------------------------------------------
	assign in_bullet_row = draw_y >= `BULLET_Y0 && draw_y < `BULLET_Y0 + `BULLET_H;

	always_comb
	begin
		bullet_slot_hit = 1'b0;
		bullet_slot     = '0;
		// slot i starts i pitches right of the first
		for (int i = 0; i < `BULLET_COUNT; i++)
		begin
			if (in_bullet_row
				&& draw_x >= `BULLET_X0 + i * `BULLET_PITCH
				&& draw_x < `BULLET_X0 + i * `BULLET_PITCH + `BULLET_W)
			begin
				bullet_slot_hit = 1'b1;
				bullet_slot     = duck_geom_pkg::bullet_count_t'(i);
			end
		end
	end

	// --------------------------------------------------
	// tally circles
	// --------------------------------------------------
	assign in_tally_band = draw_x >= `TALLY_BAND_X0 && draw_x < `TALLY_BAND_X1
		&& draw_y >= `TALLY_BAND_Y0 && draw_y < `TALLY_BAND_Y1;

	// same row for all circles
	assign tally_dy  = int'(draw_y) - `TALLY_Y;
	assign tally_dy2 = tally_dy * tally_dy;

	always_comb
	begin
		tally_hit = 1'b0;
		tally_idx = '0;
		tally_dx  = 0;
		// circles never overlap so at most one matches
		for (int i = 0; i < `TALLY_COUNT; i++)
		begin
			tally_dx = int'(draw_x) - (`TALLY_X0 + i * `TALLY_PITCH);
			if (in_tally_band && tally_dx * tally_dx + tally_dy2 <= `TALLY_R2)
			begin
				tally_hit = 1'b1;
				tally_idx = duck_geom_pkg::tally_idx_t'(i);
			end
		end
	end

	// red if that round's duck went down
	assign tally_killed = tally_hit & kill_mask[tally_idx];

endmodule
